// File: design/rv_isa_pkg.sv
// RV32I subset: field widths, instruction and data types, opcodes, funct encodings
package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int OPCODE_W  = 7;
    localparam int FUNCT3_W  = 3;
    localparam int FUNCT7_W  = 7;

    typedef logic [XLEN-1:0]      instr_t;
    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [FUNCT3_W-1:0]  funct3_t;
    typedef logic [FUNCT7_W-1:0]  funct7_t;

    // only the major opcodes this core executes
    typedef enum logic [OPCODE_W-1:0] {
        OP_IMM = 7'b0010011,
        OP_REG = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // branches
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // word access for LW and SW
    localparam funct3_t F3_WORD = 3'b010;

    // funct7 selects SUB and SRA
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

// File: design/rv_core_pkg.sv
// core control: FSM states, ALU ops, decoded instruction, memory request, memory map
package rv_core_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_FETCH_WAIT,
        S_EXEC,
        S_MEM_WAIT,
        S_HALT
    } ctrl_state_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, EQ, NE
    } alu_op_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        alu_op_e  alu_op;
        word_t    imm;
        logic     use_imm;
        logic     illegal;
    } decoded_t;

    // 65 bits
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } mem_req_t;

    // memory-mapped store targets
    localparam word_t OUT_ADDR  = 32'd1000;
    localparam word_t HALT_ADDR = 32'd1004;

    localparam word_t RESET_PC = 32'd0;

    localparam int RAM_WORDS   = 256;
    localparam int RAM_IDX_W   = $clog2(RAM_WORDS);
    localparam int RAM_LATENCY = 2;
    localparam int RAM_LAT_W   = $clog2(RAM_LATENCY + 1);

endpackage

// File: design/rv_decode.sv
// instruction decoder: field extraction, immediate generation, ALU op select
`timescale 1ns/1ps

module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
    input  instr_t   instr,
    output decoded_t dec
);
    opcode_e opc;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;

    assign opc    = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // offset counts half-words, hence the zero lsb
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        dec.opcode  = opc;
        dec.rd      = instr[11:7];
        dec.rs1     = instr[19:15];
        dec.rs2     = instr[24:20];
        dec.alu_op  = ADD;
        dec.imm     = '0;
        dec.use_imm = 1'b0;
        dec.illegal = 1'b0;
        case (opc)
            OP_IMM: begin
                // ADDI only
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.illegal = funct3 != F3_ADD_SUB;
            end
            OP_REG: begin
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: dec.alu_op = ADD;
                    {F7_ALT,  F3_ADD_SUB}: dec.alu_op = SUB;
                    {F7_BASE, F3_SLT}:     dec.alu_op = SLT;
                    {F7_BASE, F3_SLTU}:    dec.alu_op = SLTU;
                    {F7_BASE, F3_AND}:     dec.alu_op = AND;
                    {F7_BASE, F3_OR}:      dec.alu_op = OR;
                    {F7_BASE, F3_XOR}:     dec.alu_op = XOR;
                    {F7_BASE, F3_SLL}:     dec.alu_op = SLL;
                    {F7_BASE, F3_SR}:      dec.alu_op = SRL;
                    {F7_ALT,  F3_SR}:      dec.alu_op = SRA;
                    default:               dec.illegal = 1'b1;
                endcase
            end
            LOAD, STORE: begin
                // address is rs1 + offset
                dec.imm     = (opc == STORE) ? imm_s : imm_i;
                dec.use_imm = 1'b1;
                dec.illegal = funct3 != F3_WORD;
            end
            BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec.alu_op = EQ;
                    F3_BNE:  dec.alu_op = NE;
                    default: dec.illegal = 1'b1;
                endcase
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

// File: design/rv_alu.sv
// combinational ALU: add/sub, logic, shifts, compares, branch conditions
`timescale 1ns/1ps

module rv_alu import rv_isa_pkg::*, rv_core_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    cond
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        cond = 1'b0;
        case (op)
            EQ:      cond = a == b;
            NE:      cond = a != b;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            // sign bit fills from the left
            SRA:     result = $signed(a) >>> shamt;
            EQ, NE:  result = {31'b0, cond};
            default: result = '0;
        endcase
    end

endmodule

// File: design/rv_regfile.sv
// register file: 32 x 32 bits, two read ports, one write port, x0 hardwired
`timescale 1ns/1ps

module rv_regfile import rv_isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);
    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // x0 never written, stays zero from reset
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

// File: design/rv_pc.sv
// program counter: step by four or load a branch target
`timescale 1ns/1ps

module rv_pc import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  inc,
    input  logic  load,
    input  word_t target,
    output word_t pc
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (load) begin
            pc <= target;
        end else if (inc) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

// File: design/rv_ctrl.sv
// control FSM for fetch, execute, memory access, output port and halt handling
`timescale 1ns/1ps

module rv_ctrl import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  decoded_t dec,
    input  word_t    alu_result,
    input  logic     cond,
    input  word_t    rs2_data,
    input  word_t    pc,
    input  logic     mem_ack,
    input  word_t    mem_rdata,
    output instr_t   instr,
    output logic     mem_valid,
    output mem_req_t mem_req,
    output logic     rf_we,
    output word_t    rf_wdata,
    output logic     pc_inc,
    output logic     pc_load,
    output word_t    pc_target,
    output word_t    out_data,
    output logic     out_valid,
    output logic     halt
);
    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        mem_done;
    word_t       load_data;
    logic        is_out;
    logic        is_halt;

    // store address decode
    assign is_out  = dec.opcode == STORE && alu_result == OUT_ADDR;
    assign is_halt = dec.opcode == STORE && alu_result == HALT_ADDR;

    assign pc_target = pc + dec.imm;
    assign halt      = state == S_HALT;

    always_comb begin
        state_next    = state;
        mem_valid     = 1'b0;
        mem_req.addr  = alu_result;
        mem_req.wdata = rs2_data;
        mem_req.we    = 1'b0;
        rf_we         = 1'b0;
        rf_wdata      = alu_result;
        pc_inc        = 1'b0;
        pc_load       = 1'b0;
        case (state)
            S_FETCH: begin
                mem_valid    = 1'b1;
                mem_req.addr = pc;
                state_next   = S_FETCH_WAIT;
            end
            S_FETCH_WAIT: begin
                if (mem_ack) begin
                    state_next = S_EXEC;
                end
            end
            S_EXEC: begin
                if (dec.illegal || is_halt) begin
                    state_next = S_HALT;
                end else begin
                    case (dec.opcode)
                        OP_IMM, OP_REG: begin
                            rf_we      = 1'b1;
                            pc_inc     = 1'b1;
                            state_next = S_FETCH;
                        end
                        BRANCH: begin
                            pc_load    = cond;
                            pc_inc     = !cond;
                            state_next = S_FETCH;
                        end
                        LOAD: begin
                            mem_valid  = 1'b1;
                            state_next = S_MEM_WAIT;
                        end
                        STORE: begin
                            if (is_out) begin
                                pc_inc     = 1'b1;
                                state_next = S_FETCH;
                            end else begin
                                mem_valid  = 1'b1;
                                mem_req.we = 1'b1;
                                state_next = S_MEM_WAIT;
                            end
                        end
                        default: state_next = S_HALT;
                    endcase
                end
            end
            S_MEM_WAIT: begin
                // load data registered one cycle after the ack
                if (mem_done) begin
                    rf_we      = dec.opcode == LOAD;
                    rf_wdata   = load_data;
                    pc_inc     = 1'b1;
                    state_next = S_FETCH;
                end
            end
            S_HALT: state_next = S_HALT;
            default: state_next = S_HALT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_FETCH;
            mem_done  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            mem_done  <= state == S_MEM_WAIT && mem_ack;
            out_valid <= state == S_EXEC && !dec.illegal && is_out;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH_WAIT && mem_ack) begin
            instr <= mem_rdata;
        end
        if (state == S_MEM_WAIT && mem_ack) begin
            load_data <= mem_rdata;
        end
        if (state == S_EXEC && is_out) begin
            out_data <= rs2_data;
        end
    end

    // the cycle after a request is spent waiting with no new request
    a_no_req_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem_valid |=> !mem_valid && !mem_ack);

    // load writeback only in the cycle after the RAM ack
    a_rf_we_state: assert property (@(posedge clk) disable iff (rst)
        rf_we |-> state == S_EXEC || (state == S_MEM_WAIT && $past(mem_ack)));

endmodule

// File: design/rv_ram.sv
// unified instruction and data RAM with fixed-latency ack and boot write port
`timescale 1ns/1ps

module rv_ram import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid,
    input  mem_req_t req,
    input  logic     boot_we,
    input  word_t    boot_addr,
    input  word_t    boot_data,
    output logic     ack,
    output word_t    rdata
);
    word_t                mem [RAM_WORDS];
    mem_req_t             req_q;
    logic [RAM_LAT_W-1:0] lat_cnt;
    logic [RAM_IDX_W-1:0] idx;
    logic [RAM_IDX_W-1:0] boot_idx;

    // word addressed
    assign idx      = req_q.addr[RAM_IDX_W+1:2];
    assign boot_idx = boot_addr[RAM_IDX_W+1:2];

    // ack in the last cycle of the countdown
    assign ack   = lat_cnt == RAM_LAT_W'(1);
    assign rdata = mem[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_cnt <= '0;
        end else if (valid) begin
            lat_cnt <= RAM_LAT_W'(RAM_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            req_q <= req;
        end
        // program load only while the core is held in reset
        if (rst) begin
            if (boot_we) begin
                mem[boot_idx] <= boot_data;
            end
        end else if (ack && req_q.we) begin
            mem[idx] <= req_q.wdata;
        end
    end

    a_single_outstanding: assert property (@(posedge clk) disable iff (rst)
        valid |-> lat_cnt == '0);

endmodule

// File: design/rv_top.sv
// top level: control, decoder, ALU, register file, pc and RAM
`timescale 1ns/1ps

module rv_top import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  boot_we,
    input  word_t boot_addr,
    input  word_t boot_data,
    output word_t out_data,
    output logic  out_valid,
    output logic  halt
);
    instr_t   instr;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_b;
    word_t    alu_result;
    logic     cond;
    word_t    pc;
    logic     pc_inc;
    logic     pc_load;
    word_t    pc_target;
    logic     rf_we;
    word_t    rf_wdata;
    logic     mem_valid;
    mem_req_t mem_req;
    logic     mem_ack;
    word_t    mem_rdata;

    // immediate or rs2 as second operand
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    rv_ctrl u_ctrl (
        .clk(clk), .rst(rst), .dec(dec), .alu_result(alu_result), .cond(cond),
        .rs2_data(rs2_data), .pc(pc), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .instr(instr), .mem_valid(mem_valid), .mem_req(mem_req),
        .rf_we(rf_we), .rf_wdata(rf_wdata), .pc_inc(pc_inc), .pc_load(pc_load),
        .pc_target(pc_target), .out_data(out_data), .out_valid(out_valid), .halt(halt)
    );

    rv_decode u_decode (.instr(instr), .dec(dec));

    rv_alu u_alu (
        .op(dec.alu_op), .a(rs1_data), .b(alu_b), .result(alu_result), .cond(cond)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst(rst), .we(rf_we), .waddr(dec.rd), .wdata(rf_wdata),
        .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    rv_pc u_pc (
        .clk(clk), .rst(rst), .inc(pc_inc), .load(pc_load), .target(pc_target), .pc(pc)
    );

    rv_ram u_ram (
        .clk(clk), .rst(rst), .valid(mem_valid), .req(mem_req),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_data(boot_data),
        .ack(mem_ack), .rdata(mem_rdata)
    );

endmodule

// File: tb/rv_top_tb.sv
// rv_top testbench with program boot load, expected output table, halt check and watchdog
`timescale 1ns/1ps

module rv_top_tb;

    localparam int RESET_CYCLES     = 5;
    localparam int CYCLES_PER_INSTR = 7;
    localparam int LOOP_BOUND       = 5;
    localparam int MARGIN           = 100;
    localparam int QUIET_CYCLES     = 20;
    localparam logic [6:0] F7_ZERO  = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000;

    logic        clk;
    logic        rst;
    logic        boot_we;
    logic [31:0] boot_addr;
    logic [31:0] boot_data;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    logic [31:0] prog [$];
    logic [31:0] expected [$];
    int          n_out;
    bit          loaded;

    rv_top dut (
        .clk(clk), .rst(rst), .boot_we(boot_we), .boot_addr(boot_addr),
        .boot_data(boot_data), .out_data(out_data), .out_valid(out_valid), .halt(halt)
    );

    // RV32I encoders
    function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // offset in bytes with bit 0 dropped
    function automatic logic [31:0] enc_br(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // store to the output port address
    function automatic logic [31:0] enc_out(input int rs2);
        return enc_sw(rs2, 0, 1000);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] exp);
        if (actual !== exp) begin
            abort_run($sformatf("error: time %0t, %s = 0x%h, expected 0x%h",
                                $time, name, actual, exp));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        wait (loaded);
        repeat (prog.size() * CYCLES_PER_INSTR * LOOP_BOUND + prog.size() + RESET_CYCLES
                + MARGIN) @(posedge clk);
        abort_run("timeout: the program did not reach halt in time");
    end

    initial begin
        rst       = 1'b1;
        boot_we   = 1'b0;
        boot_addr = '0;
        boot_data = '0;
        n_out     = 0;
        loaded    = 1'b0;
        prog = '{
            // addi sign extension
            enc_addi(1, 0, 100), enc_out(1), enc_addi(2, 0, -7), enc_out(2),
            enc_addi(3, 1, -150), enc_out(3), enc_addi(4, 0, -1), enc_addi(5, 0, 1),
            // register-register group
            enc_op(F7_ZERO, 3'b010, 6, 4, 5), enc_out(6), enc_op(F7_ZERO, 3'b011, 6, 4, 5),
            enc_out(6), enc_op(F7_ALT, 3'b101, 6, 2, 5), enc_out(6),
            enc_op(F7_ZERO, 3'b101, 6, 2, 5), enc_out(6), enc_op(F7_ALT, 3'b000, 6, 0, 1),
            enc_out(6), enc_op(F7_ZERO, 3'b000, 6, 1, 2), enc_out(6),
            enc_op(F7_ZERO, 3'b111, 6, 1, 2), enc_out(6), enc_op(F7_ZERO, 3'b110, 6, 1, 2),
            enc_out(6), enc_op(F7_ZERO, 3'b100, 6, 1, 2), enc_out(6),
            enc_op(F7_ZERO, 3'b001, 6, 1, 5), enc_out(6),
            // countdown loop and a taken beq over one output
            enc_addi(10, 0, 5), enc_out(10), enc_addi(10, 10, -1), enc_br(3'b001, 10, 0, -8),
            enc_br(3'b000, 0, 0, 8), enc_out(1),
            // store then load back through RAM
            enc_addi(11, 0, 512), enc_addi(12, 0, -1234), enc_sw(12, 11, 8), enc_lw(13, 11, 8),
            enc_out(13),
            // x0 stays zero
            enc_addi(0, 0, 7), enc_out(0),
            // halt before a store that must never run
            enc_sw(0, 0, 1004), enc_out(1)
        };
        expected = '{
            32'd100, 32'hFFFF_FFF9, 32'hFFFF_FFCE,
            32'd1, 32'd0, 32'hFFFF_FFFC, 32'h7FFF_FFFC, 32'hFFFF_FF9C,
            32'd93, 32'h0000_0060, 32'hFFFF_FFFD, 32'hFFFF_FF9D, 32'd200,
            32'd5, 32'd4, 32'd3, 32'd2, 32'd1,
            32'hFFFF_FB2E, 32'd0
        };
        loaded = 1'b1;
        // reset held through the boot load and the reset cycles after it
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            boot_we   = 1'b1;
            boot_addr = 32'(i * 4);
            boot_data = prog[i];
        end
        @(negedge clk);
        boot_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (!halt) begin
            @(negedge clk);
            if (out_valid) begin
                if (n_out >= expected.size()) begin
                    abort_run("more outputs than entries in the expected table");
                end
                check_value("out_data", out_data, expected[n_out]);
                n_out++;
            end
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("halt", {31'b0, halt}, 32'd1);
            if (out_valid) begin
                abort_run("out_valid was raised after the core halted");
            end
        end
        if (n_out != expected.size()) begin
            abort_run($sformatf("only %0d of %0d expected outputs seen before halt",
                                n_out, expected.size()));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: rv_top.f
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_pc.sv
design/rv_ctrl.sv
design/rv_ram.sv
design/rv_top.sv
tb/rv_top_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rv_top_tb
FILELIST = rv_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
